/* logic/rv_core.sv */
// Single-cycle RV32I core
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_pkg::*; #(
    parameter word_t reset_pc = '0
) (
    input  wire logic  clk,
    input  wire logic  reset,
    output word_t      imem_addr,
    input  wire inst_u imem_data,
    output dmem_req_t  dmem_req,
    input  wire word_t dmem_rdata,
    output gpr_wr_t    gpr_trace
);

    word_t pc;
    word_t snpc;
    logic jump_en;
    word_t jump_target;
    ctrl_t ctrl;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t rs1_data;
    word_t rs2_data;
    word_t alu_result;

    assign imem_addr = pc;

    rv_fetch #(
        .reset_pc(reset_pc)
    ) u_fetch (
        .clk        (clk),
        .reset      (reset),
        .jump_en    (jump_en),
        .jump_target(jump_target),
        .pc         (pc),
        .snpc       (snpc)
    );

    rv_decode u_decode (
        .inst(imem_data),
        .ctrl(ctrl),
        .rs1 (rs1),
        .rs2 (rs2)
    );

    // trace write is the same struct that updates the registers
    rv_regfile u_regfile (
        .clk     (clk),
        .reset   (reset),
        .wr      (gpr_trace),
        .rs1     (rs1),
        .rs2     (rs2),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data)
    );

    rv_execute u_execute (
        .ctrl       (ctrl),
        .pc         (pc),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .alu_result (alu_result),
        .jump_en    (jump_en),
        .jump_target(jump_target)
    );

    rv_lsu_wb u_lsu_wb (
        .reset     (reset), // keeps enables low in reset
        .ctrl      (ctrl),
        .snpc      (snpc),
        .alu_result(alu_result),
        .rs2_data  (rs2_data),
        .dmem_rdata(dmem_rdata),
        .dmem_req  (dmem_req),
        .gpr_wr    (gpr_trace)
    );

endmodule

`default_nettype wire

/* logic/rv_decode.sv */
// Instruction decoder
`timescale 1ns/1ps
`default_nettype none

module rv_decode import rv_pkg::*; (
    input  wire inst_u inst,
    output ctrl_t      ctrl,
    output reg_addr_t  rs1,
    output reg_addr_t  rs2
);

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    // register fields sit at the same place in every format
    assign rs1 = inst.r.rs1;
    assign rs2 = inst.r.rs2;

    assign imm_i = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
    assign imm_s = {{20{inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
    assign imm_b = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                    inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
    assign imm_u = {inst.u.imm_31_12, 12'b0};
    assign imm_j = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                    inst.j.imm_11, inst.j.imm_10_1, 1'b0};

    always_comb begin
        ctrl.funct3 = inst.r.funct3;
        ctrl.alt    = inst.r.funct7[5];
        ctrl.rd     = inst.r.rd;
        case (inst.r.opcode)
            opc_op: begin // r format, no immediate
                ctrl.opcode = opc_op;
                ctrl.imm    = '0;
            end
            opc_op_imm, opc_load, opc_jalr: begin // i format
                ctrl.opcode = opcode_t'(inst.r.opcode);
                ctrl.imm    = imm_i;
            end
            opc_store: begin
                ctrl.opcode = opc_store;
                ctrl.imm    = imm_s;
            end
            opc_branch: begin
                ctrl.opcode = opc_branch;
                ctrl.imm    = imm_b;
            end
            opc_lui, opc_auipc: begin // u format
                ctrl.opcode = opcode_t'(inst.r.opcode);
                ctrl.imm    = imm_u;
            end
            opc_jal: begin
                ctrl.opcode = opc_jal;
                ctrl.imm    = imm_j;
            end
            default: begin
                // system, fence and byte ops fall through as no-ops
                ctrl.opcode = opc_none;
                ctrl.imm    = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/rv_execute.sv */
// ALU, branch and jump unit
`timescale 1ns/1ps
`default_nettype none

module rv_execute import rv_pkg::*; (
    input  wire ctrl_t ctrl,
    input  wire word_t pc,
    input  wire word_t rs1_data,
    input  wire word_t rs2_data,
    output word_t      alu_result,
    output logic       jump_en,
    output word_t      jump_target
);

    word_t alu_a;
    word_t alu_b;
    alu_op_t alu_op;
    logic take_branch;

    always_comb begin
        case (ctrl.opcode)
            opc_op: begin
                alu_a = rs1_data;
                alu_b = rs2_data;
            end
            opc_auipc, opc_jal, opc_branch: begin // pc relative
                alu_a = pc;
                alu_b = ctrl.imm;
            end
            opc_lui: begin
                alu_a = '0;
                alu_b = ctrl.imm;
            end
            default: begin // op_imm, load, store, jalr
                alu_a = rs1_data;
                alu_b = ctrl.imm;
            end
        endcase
    end

    always_comb begin
        alu_op = alu_add;
        if (ctrl.opcode == opc_op || ctrl.opcode == opc_op_imm) begin
            case (ctrl.funct3)
                3'b000: alu_op = (ctrl.opcode == opc_op && ctrl.alt) ? alu_sub : alu_add;
                3'b001: alu_op = alu_sll;
                3'b010: alu_op = alu_slt;
                3'b011: alu_op = alu_sltu;
                3'b100: alu_op = alu_xor;
                3'b101: alu_op = ctrl.alt ? alu_sra : alu_srl;
                3'b110: alu_op = alu_or;
                default: alu_op = alu_and;
            endcase
        end
    end

    always_comb begin
        case (alu_op)
            alu_sub:  alu_result = alu_a - alu_b;
            alu_sll:  alu_result = alu_a << alu_b[4:0];
            alu_slt:  alu_result = {{(xlen-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
            alu_sltu: alu_result = {{(xlen-1){1'b0}}, alu_a < alu_b};
            alu_xor:  alu_result = alu_a ^ alu_b;
            alu_srl:  alu_result = alu_a >> alu_b[4:0];
            alu_sra:  alu_result = $signed(alu_a) >>> alu_b[4:0];
            alu_or:   alu_result = alu_a | alu_b;
            alu_and:  alu_result = alu_a & alu_b;
            default:  alu_result = alu_a + alu_b; // add and address math
        endcase
    end

    always_comb begin
        case (ctrl.funct3)
            3'b000:  take_branch = (rs1_data == rs2_data);
            3'b001:  take_branch = (rs1_data != rs2_data);
            3'b100:  take_branch = ($signed(rs1_data) < $signed(rs2_data));
            3'b101:  take_branch = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  take_branch = (rs1_data < rs2_data);
            3'b111:  take_branch = (rs1_data >= rs2_data);
            default: take_branch = 1'b0; // 010 and 011 are not branches
        endcase
    end

    assign jump_en = (ctrl.opcode == opc_jal) || (ctrl.opcode == opc_jalr)
                   || (ctrl.opcode == opc_branch && take_branch);
    assign jump_target = (ctrl.opcode == opc_jalr) ? {alu_result[xlen-1:1], 1'b0}
                                                   : alu_result;

endmodule

`default_nettype wire

/* logic/rv_fetch.sv */
// Program counter
`timescale 1ns/1ps
`default_nettype none

module rv_fetch import rv_pkg::*; #(
    parameter word_t reset_pc = '0
) (
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire logic  jump_en,
    input  wire word_t jump_target,
    output word_t      pc,
    output word_t      snpc
);

    word_t dnpc;

    assign snpc = pc + word_t'(4);
    assign dnpc = jump_en ? jump_target : snpc; // taken jump wins

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else begin
            pc <= dnpc;
        end
    end

endmodule

`default_nettype wire

/* logic/rv_lsu_wb.sv */
// Data memory request and writeback select
`timescale 1ns/1ps
`default_nettype none

module rv_lsu_wb import rv_pkg::*; (
    input  wire logic  reset,
    input  wire ctrl_t ctrl,
    input  wire word_t snpc,
    input  wire word_t alu_result,
    input  wire word_t rs2_data,
    input  wire word_t dmem_rdata,
    output dmem_req_t  dmem_req,
    output gpr_wr_t    gpr_wr
);

    // word access only
    assign dmem_req.addr  = alu_result;
    assign dmem_req.wdata = rs2_data;
    assign dmem_req.we    = !reset && (ctrl.opcode == opc_store);
    assign dmem_req.re    = !reset && (ctrl.opcode == opc_load);

    assign gpr_wr.addr = ctrl.rd; // x0 filtered in the register file

    always_comb begin
        gpr_wr.en   = 1'b0;
        gpr_wr.data = alu_result;
        case (ctrl.opcode)
            opc_load: begin
                gpr_wr.en   = 1'b1;
                gpr_wr.data = dmem_rdata;
            end
            opc_jal, opc_jalr: begin // link address
                gpr_wr.en   = 1'b1;
                gpr_wr.data = snpc;
            end
            opc_op, opc_op_imm, opc_lui, opc_auipc: gpr_wr.en = 1'b1;
            default: gpr_wr.en = 1'b0; // branch, store, no-op
        endcase
        if (reset) begin
            gpr_wr.en = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* logic/rv_pkg.sv */
// RV32I core shared types
`default_nettype none

package rv_pkg;

    localparam int xlen = 32;

    typedef logic [4:0] reg_addr_t;
    typedef logic [xlen-1:0] word_t;

    typedef enum logic [6:0] {
        opc_none   = 7'b0000000, // retires as a no-op
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_t;

    // instruction formats, msb first
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t rs2;
        reg_addr_t rs1;
        logic [2:0] funct3;
        reg_addr_t rd;
        logic [6:0] opcode;
    } fmt_r_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        reg_addr_t rs1;
        logic [2:0] funct3;
        reg_addr_t rd;
        logic [6:0] opcode;
    } fmt_i_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        reg_addr_t rs2;
        reg_addr_t rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } fmt_s_t;

    typedef struct packed {
        logic imm_12;
        logic [5:0] imm_10_5;
        reg_addr_t rs2;
        reg_addr_t rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic imm_11;
        logic [6:0] opcode;
    } fmt_b_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_addr_t rd;
        logic [6:0] opcode;
    } fmt_u_t;

    typedef struct packed {
        logic imm_20;
        logic [9:0] imm_10_1;
        logic imm_11;
        logic [7:0] imm_19_12;
        reg_addr_t rd;
        logic [6:0] opcode;
    } fmt_j_t;

    typedef union packed {
        fmt_r_t r;
        fmt_i_t i;
        fmt_s_t s;
        fmt_b_t b;
        fmt_u_t u;
        fmt_j_t j;
    } inst_u;

    typedef struct packed {
        opcode_t opcode;
        logic [2:0] funct3;
        logic alt; // funct7 bit 5
        reg_addr_t rd;
        word_t imm;
    } ctrl_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic we; // store at this edge
        logic re; // load this cycle
    } dmem_req_t;

    typedef struct packed {
        logic en;
        reg_addr_t addr;
        word_t data;
    } gpr_wr_t;

endpackage

`default_nettype wire

/* logic/rv_regfile.sv */
// General register file
`timescale 1ns/1ps
`default_nettype none

module rv_regfile import rv_pkg::*; (
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire gpr_wr_t   wr,
    input  wire reg_addr_t rs1,
    input  wire reg_addr_t rs2,
    output word_t          rs1_data,
    output word_t          rs2_data
);

    word_t regs [1:31]; // x0 has no storage

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.en && (wr.addr != '0)) begin // x0 writes dropped
            regs[wr.addr] <= wr.data;
        end
    end

    // reads see the value before this cycle's write
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* sim/rv_core_asserts.sv */
// Port checks for the RV32I core
`timescale 1ns/1ps
`default_nettype none

module rv_core_asserts import rv_pkg::*; #(
    parameter word_t reset_pc = '0
) (
    input wire logic      clk,
    input wire logic      reset,
    input wire word_t     imem_addr,
    input wire inst_u     imem_data,
    input wire dmem_req_t dmem_req,
    input wire gpr_wr_t   gpr_trace
);

    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;

    int fail_count = 0;
    word_t prev_addr;
    logic [6:0] opcode;
    logic is_link;
    logic is_flow;

    assign opcode  = imem_data.r.opcode;
    assign is_link = (opcode == op_jal) || (opcode == op_jalr);
    assign is_flow = is_link || (opcode == op_branch);

    always_ff @(posedge clk) begin
        prev_addr <= imem_addr; // pc of the instruction that just retired
    end

    reset_pc_held: assert property (@(posedge clk) reset |=> imem_addr == reset_pc)
        else begin
            fail_count++;
            $error("CHECK FAILED t=%0t imem_addr got %h expected %h",
                   $time, $sampled(imem_addr), reset_pc);
        end

    reset_quiet: assert property (@(posedge clk)
        reset |-> !gpr_trace.en && !dmem_req.we && !dmem_req.re)
        else begin
            fail_count++;
            $error("CHECK FAILED t=%0t en/we/re got %b%b%b expected 000", $time,
                   $sampled(gpr_trace.en), $sampled(dmem_req.we), $sampled(dmem_req.re));
        end

    // store and load strobes follow the major opcode
    mem_strobes: assert property (@(posedge clk)
        !reset |-> dmem_req.we == (opcode == op_store) && dmem_req.re == (opcode == op_load))
        else begin
            fail_count++;
            $error("CHECK FAILED t=%0t we/re got %b%b expected %b%b", $time,
                   $sampled(dmem_req.we), $sampled(dmem_req.re),
                   $sampled(opcode == op_store), $sampled(opcode == op_load));
        end

    trace_rd: assert property (@(posedge clk)
        !reset && gpr_trace.en |-> gpr_trace.addr == imem_data.r.rd)
        else begin
            fail_count++;
            $error("CHECK FAILED t=%0t gpr_trace.addr got %h expected %h",
                   $time, $sampled(gpr_trace.addr), $sampled(imem_data.r.rd));
        end

    seq_flow: assert property (@(posedge clk)
        !reset && !is_flow |=> imem_addr == prev_addr + 32'd4)
        else begin
            fail_count++;
            $error("CHECK FAILED t=%0t imem_addr got %h expected %h",
                   $time, $sampled(imem_addr), $sampled(prev_addr) + 32'd4);
        end

    jump_flow: assert property (@(posedge clk)
        !reset && is_flow |=> imem_addr == rv_core_tb.flow_next[prev_addr[7:2]])
        else begin
            fail_count++;
            $error("CHECK FAILED t=%0t imem_addr got %h expected %h", $time,
                   $sampled(imem_addr), rv_core_tb.flow_next[$sampled(prev_addr[7:2])]);
        end

    link_value: assert property (@(posedge clk)
        !reset && is_link |-> gpr_trace.en && gpr_trace.data == imem_addr + 32'd4)
        else begin
            fail_count++;
            $error("CHECK FAILED t=%0t gpr_trace.data got %h expected %h",
                   $time, $sampled(gpr_trace.data), $sampled(imem_addr) + 32'd4);
        end

    sig_store: assert property (@(posedge clk)
        dmem_req.we && (dmem_req.addr & ~32'h3f) == rv_core_tb.sig_base
        |-> dmem_req.wdata == rv_core_tb.sig_expect[dmem_req.addr[5:2]])
        else begin
            fail_count++;
            $error("CHECK FAILED t=%0t dmem_req.wdata got %h expected %h", $time,
                   $sampled(dmem_req.wdata),
                   rv_core_tb.sig_expect[$sampled(dmem_req.addr[5:2])]);
        end

    load_value: assert property (@(posedge clk)
        dmem_req.re |-> gpr_trace.en && gpr_trace.data == rv_core_tb.dmem[dmem_req.addr[8:2]])
        else begin
            fail_count++;
            $error("CHECK FAILED t=%0t gpr_trace.data got %h expected %h", $time,
                   $sampled(gpr_trace.data), rv_core_tb.dmem[$sampled(dmem_req.addr[8:2])]);
        end

endmodule

`default_nettype wire

/* sim/rv_core_tb.sv */
// Testbench for the single-cycle core
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb import rv_pkg::*; ();

    localparam word_t sig_base    = 32'h100;
    localparam word_t halt_pc     = 32'hb0;
    localparam int    prog_words  = 45;
    localparam int    cycle_limit = 2 * prog_words + 20;

    localparam logic [6:0] op_imm   = 7'b0010011;
    localparam logic [6:0] op_load  = 7'b0000011;
    localparam logic [6:0] op_jalr  = 7'b1100111;
    localparam logic [6:0] op_lui   = 7'b0110111;
    localparam logic [6:0] op_auipc = 7'b0010111;

    logic clk;
    logic reset;
    word_t imem_addr;
    inst_u imem_data;
    dmem_req_t dmem_req;
    word_t dmem_rdata;
    gpr_wr_t gpr_trace;

    word_t dmem [0:127];
    word_t sig_expect [0:15];
    word_t flow_next [0:63]; // next pc per control-flow slot
    int cycles;

    rv_core #(
        .reset_pc(32'h0)
    ) uut (.*);

    bind rv_core rv_core_asserts #(.reset_pc(reset_pc)) chk (.*);

    // RV32I encoders
    function automatic word_t r_type(input logic [31:0] f7, rs2, rs1, f3, rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic word_t i_type(input logic [31:0] imm, rs1, f3, rd, op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic word_t s_type(input logic [31:0] imm, rs2, rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t b_type(input logic [31:0] imm, rs2, rs1, f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic word_t u_type(input logic [31:0] imm, rd, op);
        return {imm[19:0], rd[4:0], op[6:0]};
    endfunction

    function automatic word_t j_type(input logic [31:0] imm, rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic expect_next(input word_t pc, input word_t next);
        flow_next[pc[7:2]] = next;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // x1 = -20, x2 = 3, x3 = signature base
    always_comb begin
        case (imem_addr)
            32'h00: imem_data = i_type(-20, 0, 0, 1, op_imm);
            32'h04: imem_data = i_type(3, 0, 0, 2, op_imm);
            32'h08: imem_data = i_type(sig_base, 0, 0, 3, op_imm);
            32'h0c: imem_data = r_type(0, 2, 1, 0, 4);  // add
            32'h10: imem_data = s_type(0, 4, 3);
            32'h14: imem_data = r_type(32, 2, 1, 0, 4); // sub
            32'h18: imem_data = s_type(4, 4, 3);
            32'h1c: imem_data = r_type(0, 2, 1, 1, 4);  // sll
            32'h20: imem_data = s_type(8, 4, 3);
            32'h24: imem_data = r_type(0, 2, 1, 2, 4);  // slt
            32'h28: imem_data = s_type(12, 4, 3);
            32'h2c: imem_data = r_type(0, 2, 1, 3, 4);  // sltu
            32'h30: imem_data = s_type(16, 4, 3);
            32'h34: imem_data = r_type(0, 2, 1, 4, 4);  // xor
            32'h38: imem_data = s_type(20, 4, 3);
            32'h3c: imem_data = r_type(0, 2, 1, 5, 4);  // srl
            32'h40: imem_data = s_type(24, 4, 3);
            32'h44: imem_data = r_type(32, 2, 1, 5, 4); // sra
            32'h48: imem_data = s_type(28, 4, 3);
            32'h4c: imem_data = r_type(0, 2, 1, 6, 4);  // or
            32'h50: imem_data = s_type(32, 4, 3);
            32'h54: imem_data = r_type(0, 2, 1, 7, 4);  // and
            32'h58: imem_data = s_type(36, 4, 3);
            32'h5c: imem_data = u_type(32'h12345, 4, op_lui);
            32'h60: imem_data = s_type(40, 4, 3);
            32'h64: imem_data = u_type(1, 4, op_auipc);
            32'h68: imem_data = s_type(44, 4, 3);
            32'h6c: imem_data = i_type(77, 0, 0, 0, op_imm); // write to x0
            32'h70: imem_data = s_type(48, 0, 3);
            32'h74: imem_data = b_type(8, 2, 1, 0); // beq
            32'h78: imem_data = b_type(8, 2, 1, 1); // bne
            32'h80: imem_data = b_type(8, 2, 1, 4); // blt
            32'h88: imem_data = b_type(8, 2, 1, 5); // bge
            32'h8c: imem_data = b_type(8, 2, 1, 6); // bltu
            32'h90: imem_data = b_type(8, 2, 1, 7); // bgeu
            32'h98: imem_data = j_type(8, 6);
            32'ha0: imem_data = i_type(13, 6, 0, 7, op_jalr); // odd target, bit 0 dropped
            32'ha8: imem_data = i_type(0, 3, 2, 8, op_load);  // reads back the add result
            32'hac: imem_data = i_type(64, 3, 2, 9, op_load); // untouched random word
            32'hb0: imem_data = j_type(0, 0); // park here
            32'h7c, 32'h84, 32'h94, 32'h9c, 32'ha4: begin
                imem_data = i_type(1, 0, 0, 5, op_imm); // only on a wrong jump
            end
            default: imem_data = '0;
        endcase
    end

    always @(posedge clk) begin
        if (dmem_req.we) begin
            dmem[dmem_req.addr[8:2]] <= dmem_req.wdata;
        end
    end

    assign dmem_rdata = dmem[dmem_req.addr[8:2]];

    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: pc %h never reached %h within %0d cycles", imem_addr, halt_pc,
                 cycle_limit);
        $display("Errors found");
        $finish;
    end

    initial begin
        void'($urandom(69));
        reset = 1'b1;
        for (int i = 0; i < 128; i++) begin
            dmem[i] = $urandom;
        end
        sig_expect = '{
            32'hffffffef, 32'hffffffe9, 32'hffffff60, 32'h00000001, // add sub sll slt
            32'h00000000, 32'hffffffef, 32'h1ffffffd, 32'hfffffffd, // sltu xor srl sra
            32'hffffffef, 32'h00000000, 32'h12345000, 32'h00001064, // or and lui auipc
            32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000  // x0 then unused
        };
        expect_next(32'h74, 32'h78); // not taken
        expect_next(32'h78, 32'h80);
        expect_next(32'h80, 32'h88);
        expect_next(32'h88, 32'h8c); // not taken
        expect_next(32'h8c, 32'h90); // not taken
        expect_next(32'h90, 32'h98);
        expect_next(32'h98, 32'ha0);
        expect_next(32'ha0, 32'ha8);
        expect_next(32'hb0, 32'hb0);
        repeat (2) @(negedge clk);
        reset = 1'b0;
        while (imem_addr !== halt_pc) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
        $display("run finished after %0d cycles with %0d assertion failures", cycles,
                 uut.chk.fail_count);
        if (uut.chk.fail_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
logic/rv_pkg.sv
logic/rv_fetch.sv
logic/rv_decode.sv
logic/rv_regfile.sv
logic/rv_execute.sv
logic/rv_lsu_wb.sv
logic/rv_core.sv
sim/rv_core_asserts.sv
sim/rv_core_tb.sv
